//--- source/iagcLogPkg.sv
package iagcLogPkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Data widths.
  // ~~~~~~~~~~~~~~~~~~~~

  // One UART data byte.
  typedef logic [7:0] byte_t;

  // Reference and error amplitudes are sent low byte first.
  typedef logic [15:0] amplitude_t;

  // Status code of the gain control loop.
  typedef logic [3:0] iagcStatus_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Status codes.
  // ~~~~~~~~~~~~~~~~~~~~

  // Logging is inhibited while the loop reports either of these.
  localparam iagcStatus_t iagcStatusReset = 4'd0;
  localparam iagcStatus_t iagcStatusInit  = 4'd1;

  // ~~~~~~~~~~~~~~~~~~~~
  // Frame geometry.
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int frameLength = 7; // Bytes per frame.

  // Position of a byte within a frame.
  typedef logic [2:0] byteIndex_t;

endpackage

//--- source/uartSerializer.sv
`timescale 1ns/100ps

module uartSerializer #(
  parameter int clocksPerBit = 868
) (
  input  logic               i_clock,
  input  logic               i_reset,
  input  logic               i_byteReq,
  input  iagcLogPkg::byte_t  i_byteData,
  output logic               o_byteAck,
  output logic               o_txBit
);

  import iagcLogPkg::*;

  typedef enum logic [2:0] {
    Idle,
    Start,
    Data,
    Stop,
    AckHold
  } serialState_t;

  localparam int tickWidth = $clog2(clocksPerBit);

  serialState_t         state;
  logic [tickWidth-1:0] tickCount;
  logic                 lastTick;
  logic [2:0]           bitIndex;
  byte_t                shiftReg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Bit timing.
  // ~~~~~~~~~~~~~~~~~~~~

  assign lastTick = (tickCount == tickWidth'(clocksPerBit - 1));

  // ~~~~~~~~~~~~~~~~~~~~
  // Transmit FSM.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state     <= Idle;
      tickCount <= '0;
      bitIndex  <= '0;
      o_txBit   <= 1'b1; // Line idles high.
    end else begin
      case (state)
        Idle: begin
          if (i_byteReq) begin
            tickCount <= '0;
            o_txBit   <= 1'b0; // Start bit.
            state     <= Start;
          end
        end

        Start: begin
          if (lastTick) begin
            tickCount <= '0;
            bitIndex  <= '0;
            o_txBit   <= shiftReg[0];
            state     <= Data;
          end else begin
            tickCount <= tickCount + 1'b1;
          end
        end

        Data: begin
          if (lastTick) begin
            tickCount <= '0;
            if (bitIndex == 3'd7) begin
              o_txBit <= 1'b1; // Stop bit.
              state   <= Stop;
            end else begin
              o_txBit  <= shiftReg[0];
              bitIndex <= bitIndex + 1'b1;
            end
          end else begin
            tickCount <= tickCount + 1'b1;
          end
        end

        Stop: begin
          if (lastTick) begin
            tickCount <= '0;
            state     <= AckHold;
          end else begin
            tickCount <= tickCount + 1'b1;
          end
        end

        // Hold the ack until the request is withdrawn.
        AckHold: begin
          if (!i_byteReq) begin
            state <= Idle;
          end
        end

        default: begin
          state   <= Idle;
          o_txBit <= 1'b1;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Data path.
  // ~~~~~~~~~~~~~~~~~~~~

  // LSB leaves first, so the register shifts right after each bit is taken.
  always_ff @(posedge i_clock) begin
    if (state == Idle && i_byteReq) begin
      shiftReg <= i_byteData;
    end else if ((state == Start || state == Data) && lastTick) begin
      shiftReg <= shiftReg >> 1;
    end
  end

  // Ack covers the last cycle of the stop bit and the hold that follows.
  assign o_byteAck = (state == Stop && lastTick) || (state == AckHold);

endmodule

//--- source/frameLogger.sv
`timescale 1ns/100ps

module frameLogger #(
  parameter int logInterval = 60000000
) (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  iagcLogPkg::iagcStatus_t i_iagcStatus,
  input  iagcLogPkg::amplitude_t  i_referenceAmplitude,
  input  iagcLogPkg::amplitude_t  i_errorAmplitude,
  input  iagcLogPkg::byte_t       i_quotient,
  input  iagcLogPkg::byte_t       i_fractional,
  input  logic                    i_onPhase,
  input  logic                    i_wdValid,
  input  logic                    i_byteAck,
  output logic                    o_byteReq,
  output iagcLogPkg::byte_t       o_byteData,
  output logic                    o_serializerClear
);

  import iagcLogPkg::*;

  typedef enum logic [2:0] {
    Inhibit,
    Count,
    Request,
    AwaitAck,
    Release,
    Next
  } loggerState_t;

  localparam int         countWidth = $clog2(logInterval + 1);
  localparam int         byteWidth  = $bits(byte_t);
  localparam byteIndex_t lastByte   = byteIndex_t'(frameLength - 1);

  loggerState_t          state;
  logic                  inhibit;
  logic                  intervalDone;
  logic [countWidth-1:0] intervalCount;
  byteIndex_t            byteIndex;

  amplitude_t            refSnap;
  amplitude_t            errSnap;
  byte_t                 quotSnap;
  byte_t                 fracSnap;
  byte_t                 flagSnap;
  byte_t                 frameByte;
  byte_t                 dataReg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Inhibit.
  // ~~~~~~~~~~~~~~~~~~~~

  assign inhibit = (i_iagcStatus == iagcStatusReset) || (i_iagcStatus == iagcStatusInit);

  // The serializer drops any byte in flight while logging is held off.
  assign o_serializerClear = i_reset || inhibit;

  assign intervalDone = (intervalCount == countWidth'(logInterval));

  // ~~~~~~~~~~~~~~~~~~~~
  // Sequencer FSM.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clock) begin
    if (i_reset || inhibit) begin
      state         <= Inhibit;
      intervalCount <= '0;
      byteIndex     <= '0;
    end else begin
      case (state)
        Inhibit: begin
          intervalCount <= intervalCount + 1'b1; // Release edge is the first counted cycle.
          state         <= Count;
        end

        Count: begin
          if (intervalDone) begin
            byteIndex <= '0;
            state     <= Next; // Snapshot is taken on this edge.
          end else begin
            intervalCount <= intervalCount + 1'b1;
          end
        end

        // Wait for the previous handshake to close, then present a byte.
        Next: begin
          if (!i_byteAck) begin
            state <= Request;
          end
        end

        Request: begin
          state <= AwaitAck;
        end

        AwaitAck: begin
          if (i_byteAck) begin
            state <= Release;
          end
        end

        Release: begin
          if (byteIndex == lastByte) begin
            intervalCount <= '0;
            state         <= Count;
          end else begin
            byteIndex <= byteIndex + 1'b1;
            state     <= Next;
          end
        end

        default: begin
          state <= Inhibit;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Snapshot and frame data.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clock) begin
    if (state == Count && intervalDone) begin
      refSnap  <= i_referenceAmplitude;
      errSnap  <= i_errorAmplitude;
      quotSnap <= i_quotient;
      fracSnap <= i_fractional;
      flagSnap <= {{(byteWidth - 2){1'b0}}, i_wdValid, i_onPhase};
    end
  end

  // Frame layout, amplitudes low byte first.
  always_comb begin
    case (byteIndex)
      3'd0:    frameByte = refSnap[byteWidth-1:0];
      3'd1:    frameByte = refSnap[2*byteWidth-1:byteWidth];
      3'd2:    frameByte = errSnap[byteWidth-1:0];
      3'd3:    frameByte = errSnap[2*byteWidth-1:byteWidth];
      3'd4:    frameByte = quotSnap;
      3'd5:    frameByte = fracSnap;
      default: frameByte = flagSnap;
    endcase
  end

  // Loaded only while req and ack are both low.
  always_ff @(posedge i_clock) begin
    if (state == Next && !i_byteAck) begin
      dataReg <= frameByte;
    end
  end

  assign o_byteData = dataReg;
  assign o_byteReq  = (state == Request) || (state == AwaitAck);

endmodule

//--- source/iagcTelemetry.sv
`timescale 1ns/100ps

module iagcTelemetry #(
  parameter int clocksPerBit = 868,
  parameter int logInterval  = 60000000
) (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  iagcLogPkg::iagcStatus_t i_iagcStatus,
  input  iagcLogPkg::amplitude_t  i_referenceAmplitude,
  input  iagcLogPkg::amplitude_t  i_errorAmplitude,
  input  iagcLogPkg::byte_t       i_quotient,
  input  iagcLogPkg::byte_t       i_fractional,
  input  logic                    i_onPhase,
  input  logic                    i_wdValid,
  output logic                    o_txBit
);

  import iagcLogPkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // Byte handshake.
  // ~~~~~~~~~~~~~~~~~~~~

  logic  byteReq;
  logic  byteAck;
  byte_t byteData;
  logic  serializerClear;

  frameLogger #(
    .logInterval(logInterval)
  ) frameLog (
    .i_clock             (i_clock),
    .i_reset             (i_reset),
    .i_iagcStatus        (i_iagcStatus),
    .i_referenceAmplitude(i_referenceAmplitude),
    .i_errorAmplitude    (i_errorAmplitude),
    .i_quotient          (i_quotient),
    .i_fractional        (i_fractional),
    .i_onPhase           (i_onPhase),
    .i_wdValid           (i_wdValid),
    .i_byteAck           (byteAck),
    .o_byteReq           (byteReq),
    .o_byteData          (byteData),
    .o_serializerClear   (serializerClear)
  );

  // Cleared by the logger on reset or inhibit.
  uartSerializer #(
    .clocksPerBit(clocksPerBit)
  ) uartTx (
    .i_clock   (i_clock),
    .i_reset   (serializerClear),
    .i_byteReq (byteReq),
    .i_byteData(byteData),
    .o_byteAck (byteAck),
    .o_txBit   (o_txBit)
  );

endmodule

//--- verif/telemetry_properties.sv
`timescale 1ns/100ps

module telemetry_properties (
  input logic              i_clock,
  input logic              i_clear,
  input logic              i_byteReq,
  input iagcLogPkg::byte_t i_byteData,
  input logic              i_byteAck,
  input logic              i_txBit
);

  int failCount = 0;

  // ~~~~~~~~~~~~~~~~~~~~
  // Four-phase handshake.
  // ~~~~~~~~~~~~~~~~~~~~

  property dataHeldDuringReq;
    @(posedge i_clock) disable iff (i_clear)
      i_byteReq && $past(i_byteReq) |-> $stable(i_byteData);
  endproperty

  property ackOnlyWithReq;
    @(posedge i_clock) disable iff (i_clear)
      $rose(i_byteAck) |-> i_byteReq;
  endproperty

  property reqNotDuringAck;
    @(posedge i_clock) disable iff (i_clear)
      $rose(i_byteReq) |-> !i_byteAck;
  endproperty

  // Line is registered, so it answers one edge later.
  property lineHighWhenCleared;
    @(posedge i_clock) i_clear |=> i_txBit;
  endproperty

  assert property (dataHeldDuringReq) else begin
    failCount++;
    $error("byteData changed while byteReq was high");
  end

  assert property (ackOnlyWithReq) else begin
    failCount++;
    $error("byteAck rose without byteReq");
  end

  assert property (reqNotDuringAck) else begin
    failCount++;
    $error("byteReq rose while byteAck was still high");
  end

  assert property (lineHighWhenCleared) else begin
    failCount++;
    $error("Serial line not idle after clear");
  end

endmodule

bind uartSerializer telemetry_properties handshakeProps (
  .i_clock   (i_clock),
  .i_clear   (i_reset),
  .i_byteReq (i_byteReq),
  .i_byteData(i_byteData),
  .i_byteAck (o_byteAck),
  .i_txBit   (o_txBit)
);

//--- verif/telemetryChecker.sv
`timescale 1ns/100ps

module telemetryChecker #(
  parameter int clocksPerBit = 8,
  parameter int logInterval  = 40
) (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  iagcLogPkg::iagcStatus_t i_iagcStatus,
  input  iagcLogPkg::amplitude_t  i_referenceAmplitude,
  input  iagcLogPkg::amplitude_t  i_errorAmplitude,
  input  iagcLogPkg::byte_t       i_quotient,
  input  iagcLogPkg::byte_t       i_fractional,
  input  logic                    i_onPhase,
  input  logic                    i_wdValid,
  input  logic                    i_txBit,
  output int                      o_frameCount,
  output int                      o_byteIndex,
  output int                      o_discardCount,
  output int                      o_errorCount
);

  import iagcLogPkg::*;

  typedef enum int {GapByte, GapFrame, GapRelease} gapKind_t;

  localparam int byteCycles = 10 * clocksPerBit;
  localparam int midBit     = clocksPerBit / 2;
  localparam int byteGap    = 3;
  localparam int frameGap   = logInterval + 4;
  // Idle cycles from the first released edge to the first start bit.
  localparam int releaseGap = logInterval + 2;

  amplitude_t refHist  [0:2];
  amplitude_t errHist  [0:2];
  byte_t      quotHist [0:2];
  byte_t      fracHist [0:2];
  logic [1:0] flagHist [0:2]; // {wdValid, onPhase}.
  byte_t      frameBytes [0:frameLength-1];

  logic     clearSeen    = 1'b1;
  logic     busy         = 1'b0;
  logic     bitRef;
  byte_t    rxByte;
  int       bitCycle;
  int       gapCount     = 0;
  gapKind_t gapKind      = GapRelease;
  int       testFrames   = 0;
  int       testDiscards = 0;
  int       testErrors   = 0;

  initial begin
    o_frameCount   = 0;
    o_byteIndex    = 0;
    o_discardCount = 0;
    o_errorCount   = 0;
  end

  task automatic mismatch(input string what, input logic [15:0] expectedValue,
                          input logic [15:0] actualValue);
    $display("ERROR at %0t: %s expected %0d actual %0d", $time, what, expectedValue,
             actualValue);
    o_errorCount++;
    testErrors++;
  endtask

  task automatic problem(input string what);
    $display("Failure at %0t: %s", $time, what);
    o_errorCount++;
    testErrors++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Input history.
  // ~~~~~~~~~~~~~~~~~~~~

  always @(posedge i_clock) begin
    for (int i = 2; i > 0; i--) begin
      refHist[i]  = refHist[i-1];
      errHist[i]  = errHist[i-1];
      quotHist[i] = quotHist[i-1];
      fracHist[i] = fracHist[i-1];
      flagHist[i] = flagHist[i-1];
    end
    refHist[0]  = i_referenceAmplitude;
    errHist[0]  = i_errorAmplitude;
    quotHist[0] = i_quotient;
    fracHist[0] = i_fractional;
    flagHist[0] = {i_wdValid, i_onPhase};
    clearSeen   = i_reset || (i_iagcStatus == iagcStatusReset) ||
                  (i_iagcStatus == iagcStatusInit);
  end

  // Snapshot edge lies two edges before the start bit.
  task automatic captureFrame();
    frameBytes[0] = refHist[2][7:0];
    frameBytes[1] = refHist[2][15:8];
    frameBytes[2] = errHist[2][7:0];
    frameBytes[3] = errHist[2][15:8];
    frameBytes[4] = quotHist[2];
    frameBytes[5] = fracHist[2];
    frameBytes[6] = {6'b000000, flagHist[2]};
  endtask

  task automatic checkGap();
    int expectedGap;
    case (gapKind)
      GapByte:  expectedGap = byteGap;
      GapFrame: expectedGap = frameGap;
      default:  expectedGap = releaseGap;
    endcase
    if (gapCount != expectedGap) begin
      mismatch($sformatf("o_txBit idle cycles before byte %0d", o_byteIndex),
               expectedGap, gapCount);
    end
  endtask

  task automatic sampleBit(input int bitNumber);
    if (bitNumber == 0) begin
      if (i_txBit !== 1'b0) mismatch("o_txBit start bit", 0, i_txBit);
    end else if (bitNumber <= 8) begin
      rxByte[bitNumber-1] = i_txBit; // LSB arrives first.
    end else if (i_txBit !== 1'b1) begin
      mismatch("o_txBit stop bit", 1, i_txBit);
    end
  endtask

  task automatic finishByte();
    if (rxByte !== frameBytes[o_byteIndex]) begin
      mismatch($sformatf("o_txBit byte %0d", o_byteIndex), frameBytes[o_byteIndex], rxByte);
    end
    busy     = 1'b0;
    gapCount = 0;
    o_byteIndex++;
    if (o_byteIndex == frameLength) begin
      o_byteIndex = 0;
      o_frameCount++;
      testFrames++;
      gapKind = GapFrame;
    end else begin
      gapKind = GapByte;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Line decoder.
  // ~~~~~~~~~~~~~~~~~~~~

  always @(negedge i_clock) begin
    if (clearSeen) begin
      if (i_txBit !== 1'b1) problem("o_txBit was not idle while the logger was cleared");
      if (busy || o_byteIndex != 0) begin
        o_discardCount++; // Partial frame thrown away.
        testDiscards++;
      end
      busy        = 1'b0;
      o_byteIndex = 0;
      gapKind     = GapRelease;
      gapCount    = 0;
    end else if (!busy) begin
      if (i_txBit === 1'b1) begin
        gapCount++;
      end else begin
        checkGap();
        if (o_byteIndex == 0) captureFrame();
        busy     = 1'b1;
        bitCycle = 0;
        bitRef   = i_txBit;
      end
    end else begin
      bitCycle++;
      if (bitCycle % clocksPerBit == 0) begin
        bitRef = i_txBit;
      end else if (i_txBit !== bitRef) begin
        problem($sformatf("bit %0d of byte %0d changed before its period ended",
                          bitCycle / clocksPerBit, o_byteIndex));
      end
      if (bitCycle % clocksPerBit == midBit) sampleBit(bitCycle / clocksPerBit);
      if (bitCycle == byteCycles - 1) finishByte();
    end
  end

  task automatic testSummary(input string name, input int expFrames, input int expDiscards);
    if (testFrames != expFrames) begin
      problem($sformatf("%s completed %0d frames instead of %0d", name, testFrames, expFrames));
    end
    if (testDiscards != expDiscards) begin
      problem($sformatf("%s discarded %0d frames instead of %0d", name, testDiscards,
                        expDiscards));
    end
    $display("Test %-20s frames %0d, discarded %0d, errors %0d, %s", name, testFrames,
             testDiscards, testErrors, (testErrors == 0) ? "ok" : "failed");
    testFrames   = 0;
    testDiscards = 0;
    testErrors   = 0;
  endtask

endmodule

//--- verif/iagcTelemetryTb.sv
`timescale 1ns/100ps

module iagcTelemetryTb;

  import iagcLogPkg::*;

  localparam int clocksPerBit  = 8;
  localparam int logInterval   = 40;
  localparam int frameCycles   = frameLength * (10 * clocksPerBit + 3) + logInterval + 4;
  localparam int timeoutCycles = 12 * frameCycles * 5 / 4;

  logic        clock = 1'b0;
  logic        reset;
  iagcStatus_t iagcStatus;
  amplitude_t  referenceAmplitude;
  amplitude_t  errorAmplitude;
  byte_t       quotient;
  byte_t       fractional;
  logic        onPhase;
  logic        wdValid;
  logic        txBit;

  int          frameCount;
  int          byteIndex;
  int          discardCount;
  int          errorCount;
  int          cycleCount = 0;
  int          assertFailures;
  integer      seed = 76581;

  always #4 clock = ~clock;

  iagcTelemetry #(
    .clocksPerBit(clocksPerBit),
    .logInterval (logInterval)
  ) dut (
    .i_clock             (clock),
    .i_reset             (reset),
    .i_iagcStatus        (iagcStatus),
    .i_referenceAmplitude(referenceAmplitude),
    .i_errorAmplitude    (errorAmplitude),
    .i_quotient          (quotient),
    .i_fractional        (fractional),
    .i_onPhase           (onPhase),
    .i_wdValid           (wdValid),
    .o_txBit             (txBit)
  );

  telemetryChecker #(
    .clocksPerBit(clocksPerBit),
    .logInterval (logInterval)
  ) monitor (
    .i_clock             (clock),
    .i_reset             (reset),
    .i_iagcStatus        (iagcStatus),
    .i_referenceAmplitude(referenceAmplitude),
    .i_errorAmplitude    (errorAmplitude),
    .i_quotient          (quotient),
    .i_fractional        (fractional),
    .i_onPhase           (onPhase),
    .i_wdValid           (wdValid),
    .i_txBit             (txBit),
    .o_frameCount        (frameCount),
    .o_byteIndex         (byteIndex),
    .o_discardCount      (discardCount),
    .o_errorCount        (errorCount)
  );

  // Measurements change every cycle.
  always @(negedge clock) begin
    referenceAmplitude <= amplitude_t'($random(seed));
    errorAmplitude     <= amplitude_t'($random(seed));
    quotient           <= byte_t'($random(seed));
    fractional         <= byte_t'($random(seed));
    onPhase            <= $random(seed);
    wdValid            <= $random(seed);
  end

  // Any code other than Reset or Init lets the logger run.
  function automatic iagcStatus_t pickRunStatus();
    return iagcStatus_t'(2 + ($unsigned($random(seed)) % 14));
  endfunction

  task automatic waitCycles(input int count);
    repeat (count) @(negedge clock);
  endtask

  task automatic waitFrames(input int count);
    int target;
    target = frameCount + count;
    wait (frameCount >= target);
    @(negedge clock);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    reset              = 1'b1;
    iagcStatus         = iagcStatusReset;
    referenceAmplitude = '0;
    errorAmplitude     = '0;
    quotient           = '0;
    fractional         = '0;
    onPhase            = 1'b0;
    wdValid            = 1'b0;
    waitCycles(5);
    reset = 1'b0;
    waitCycles(10);

    iagcStatus = pickRunStatus();
    waitFrames(3);
    monitor.testSummary("frame content", 3, 0);

    iagcStatus = iagcStatusReset;
    waitCycles(3 * logInterval);
    iagcStatus = iagcStatusInit;
    waitCycles(3 * logInterval);
    monitor.testSummary("status held", 0, 0);

    iagcStatus = pickRunStatus();
    wait (byteIndex == 3);
    waitCycles(20); // Inside byte 3.
    iagcStatus = iagcStatus_t'($unsigned($random(seed)) % 2);
    waitCycles(10);
    iagcStatus = pickRunStatus();
    waitFrames(2);
    monitor.testSummary("inhibit mid-frame", 2, 1);

    wait (byteIndex == 5);
    waitCycles(30);
    reset = 1'b1;
    waitCycles(3);
    reset = 1'b0;
    waitFrames(2);
    monitor.testSummary("reset mid-frame", 2, 1);

    assertFailures = dut.uartTx.handshakeProps.failCount;
    $display("Tests 4, frames %0d, discarded %0d, check errors %0d, assertion failures %0d",
             frameCount, discardCount, errorCount, assertFailures);
    if (errorCount == 0 && assertFailures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    while (cycleCount < timeoutCycles) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- src.f
source/iagcLogPkg.sv
source/uartSerializer.sv
source/frameLogger.sv
source/iagcTelemetry.sv
verif/telemetry_properties.sv
verif/telemetryChecker.sv
verif/iagcTelemetryTb.sv
